// ==== sim.f ====
+incdir+.
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_apb_regs.sv
rv_decode.sv
rv_alu.sv
rv_result.sv
rv_alu_top.sv
tb_clk_gen.sv
rv_alu_assert.sv
rv_alu_tb.sv

// ==== Bender.yml ====
package:
  name: rv_alu

sources:
  - target: rtl
    include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_bus_pkg.sv
      - rv_apb_regs.sv
      - rv_decode.sv
      - rv_alu.sv
      - rv_result.sv
      - rv_alu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - rv_alu_assert.sv
      - rv_alu_tb.sv

// ==== rv_alu_tb.sv ====
`timescale 1ns/1ps
`include "rv_alu_macros.svh"

module rv_alu_tb;

	localparam int N_TESTS   = 6;
	localparam int TEST_CYC  = 800; // Longest test is about 600 cycles
	localparam int PERIOD_NS = 100;

	logic                  clk;
	logic                  reset;
	logic [`RV_APB_AW-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [`RV_XLEN-1:0]   pwdata;
	logic [`RV_XLEN-1:0]   prdata;
	logic                  pready;
	logic                  pslverr;
	logic [11:0]           imm;
	int                    n_run;
	int                    n_fail;
	int                    last_cnt;

	tb_clk_gen u_clk (
		.clk_o(clk),
		.reset_o(reset)
	);

	rv_alu_top UUT (
		.clk_i(clk), .reset_i(reset),
		.paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
	);

	bind rv_alu_top rv_alu_assert u_chk (
		.clk_i, .reset_i, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
		.prdata_i(prdata_o), .pready_i(pready_o), .pslverr_i(pslverr_o),
		.state_i(u_result.state)
	);

	// Starts and ends on a falling edge
	task automatic apb_xfer(input logic wr, input logic [`RV_APB_AW-1:0] addr,
			input logic [`RV_XLEN-1:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		#(PERIOD_NS / 4); // Settled well before the rising edge
		while (!pready) begin
			@(negedge clk);
			#(PERIOD_NS / 4);
		end
		@(negedge clk); // Completed on the rising edge just passed
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic launch_and_read(input logic [31:0] instr, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic [31:0] pc);
		apb_xfer(1'b1, `RV_REG_INSTR, instr);
		apb_xfer(1'b1, `RV_REG_RS1, rs1);
		apb_xfer(1'b1, `RV_REG_RS2, rs2);
		apb_xfer(1'b1, `RV_REG_PC, pc);
		apb_xfer(1'b1, `RV_REG_CTRL, 32'h1);
		apb_xfer(1'b0, `RV_REG_RESULT, '0); // Lands while busy
		apb_xfer(1'b0, `RV_REG_STATUS, '0);
	endtask

	task automatic reg_op_set(input logic f7_b5, input logic [2:0] f3);
		logic [31:0] instr;
		instr = {1'b0, f7_b5, 5'b0, 5'd2, 5'd1, f3, 5'd3, rv_isa_pkg::OP_REG};
		launch_and_read(instr, $urandom, $urandom, '0);
		launch_and_read(instr, 32'h8000_0000, 32'hFFFF_FFFF, '0);
		launch_and_read(instr, $urandom, 32'd0, '0);
		launch_and_read(instr, 32'h8000_0000, 32'd31, '0);
	endtask

	task automatic imm_op(input logic [11:0] imm12, input logic [2:0] f3,
			input logic [31:0] rs1);
		launch_and_read({imm12, 5'd1, f3, 5'd3, rv_isa_pkg::OP_IMM}, rs1, $urandom, '0);
	endtask

	task automatic report_test(input string name);
		int now;
		now = UUT.u_chk.fail_cnt;
		if (now == last_cnt) begin
			$display("%0t  %s: ok", $time, name);
		end else begin
			$display("%0t  %s: %0d assertion failures", $time, name, now - last_cnt);
			n_fail++;
		end
		last_cnt = now;
		n_run++;
	endtask

	initial begin
		void'($urandom(32'h1018_5331));
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		n_run    = 0;
		n_fail   = 0;
		last_cnt = 0;
		wait (!reset);

		apb_xfer(1'b0, `RV_REG_RESULT, '0);
		apb_xfer(1'b0, `RV_REG_STATUS, '0);
		report_test("reset values");

		for (int f = 0; f < 8; f++)
			reg_op_set(1'b0, 3'(f));
		reg_op_set(1'b1, rv_isa_pkg::F3_ADD); // SUB
		reg_op_set(1'b1, rv_isa_pkg::F3_SR);  // SRA
		report_test("register ops");

		for (int f = 0; f < 8; f++) begin
			imm = (f == 1 || f == 5) ? {7'b0, 5'($urandom)} : 12'($urandom);
			imm_op(imm, 3'(f), $urandom);
		end
		imm_op(12'h41F, rv_isa_pkg::F3_SR, 32'h8000_0000); // SRAI by 31
		imm_op(12'hFFF, rv_isa_pkg::F3_SLT, 32'h0000_0001);
		imm_op(12'hF00, rv_isa_pkg::F3_SLT, 32'hFFFF_FED4);
		imm_op(12'h800, rv_isa_pkg::F3_SLTU, 32'h7FFF_FFFF);
		launch_and_read({20'($urandom), 5'd3, rv_isa_pkg::OP_LUI}, $urandom, $urandom, '0);
		launch_and_read({20'($urandom), 5'd3, rv_isa_pkg::OP_AUIPC}, $urandom, $urandom,
			$urandom);
		report_test("immediate and upper ops");

		imm_op(12'h123, rv_isa_pkg::F3_ADD, 32'h0000_1000);
		imm_op(12'h456, rv_isa_pkg::F3_XOR, 32'hA5A5_A5A5);
		report_test("result stall");

		launch_and_read(32'h0020_8063, $urandom, $urandom, $urandom); // BEQ
		launch_and_read(32'h0000_A183, $urandom, $urandom, $urandom); // LW
		report_test("illegal opcodes");

		apb_xfer(1'b1, `RV_REG_RESULT, 32'hDEAD_BEEF);
		apb_xfer(1'b1, `RV_REG_STATUS, 32'hFFFF_FFFF);
		apb_xfer(1'b1, 8'h1C, 32'h1234_5678);
		apb_xfer(1'b0, 8'h40, '0);
		apb_xfer(1'b0, `RV_REG_RESULT, '0);
		apb_xfer(1'b0, `RV_REG_STATUS, '0);
		// Operand registers untouched by the rejected accesses
		apb_xfer(1'b0, `RV_REG_INSTR, '0);
		apb_xfer(1'b0, `RV_REG_RS1, '0);
		apb_xfer(1'b0, `RV_REG_RS2, '0);
		apb_xfer(1'b0, `RV_REG_PC, '0);
		report_test("slave errors");

		$display("Tests run %0d, failed %0d, assertion failures %0d",
			n_run, n_fail, UUT.u_chk.fail_cnt);
		if (n_fail == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		#(N_TESTS * TEST_CYC * PERIOD_NS * 2);
		$display("Watchdog expired, an APB transfer never completed");
		$display("test failed");
		$finish;
	end

endmodule

// ==== rv_alu_assert.sv ====
`timescale 1ns/1ps
`include "rv_alu_macros.svh"

module rv_alu_assert (
	input logic                      clk_i,
	input logic                      reset_i,
	input logic [`RV_APB_AW-1:0]     paddr_i,
	input logic                      psel_i,
	input logic                      penable_i,
	input logic                      pwrite_i,
	input logic [`RV_XLEN-1:0]       pwdata_i,
	input logic [`RV_XLEN-1:0]       prdata_i,
	input logic                      pready_i,
	input logic                      pslverr_i,
	input rv_bus_pkg::launch_state_e state_i
);

	int                        fail_cnt = 0;
	logic [`RV_XLEN-1:0]       instr;
	logic [`RV_XLEN-1:0]       rs1;
	logic [`RV_XLEN-1:0]       rs2;
	logic [`RV_XLEN-1:0]       pc;
	logic [`RV_XLEN-1:0]       exp_res;
	logic [`RV_XLEN-1:0]       exp_rd;
	logic                      exp_ill;
	logic                      exp_done;
	logic                      access;
	logic                      ro;
	logic                      mapped;
	logic                      rd_chk;
	logic                      exp_err;
	logic                      launch_wr;
	logic                      pend_dec;
	logic                      pend_exec;
	logic                      in_flight;
	rv_bus_pkg::launch_state_e exp_state;

	assign access  = psel_i & penable_i;
	assign ro      = paddr_i == `RV_REG_RESULT || paddr_i == `RV_REG_STATUS;
	assign mapped  = ro || paddr_i inside {`RV_REG_INSTR, `RV_REG_RS1, `RV_REG_RS2,
		`RV_REG_PC, `RV_REG_CTRL};
	assign rd_chk  = mapped && paddr_i != `RV_REG_CTRL;
	assign exp_err = !mapped || (ro && pwrite_i);

	assign launch_wr = access && pready_i && pwrite_i && paddr_i == `RV_REG_CTRL;
	assign in_flight = pend_dec || pend_exec;
	assign exp_state = pend_exec ? rv_bus_pkg::LS_EXEC :
		pend_dec ? rv_bus_pkg::LS_DECODE : rv_bus_pkg::LS_IDLE;

	always_comb begin
		case (paddr_i)
			`RV_REG_INSTR:  exp_rd = instr;
			`RV_REG_RS1:    exp_rd = rs1;
			`RV_REG_RS2:    exp_rd = rs2;
			`RV_REG_PC:     exp_rd = pc;
			`RV_REG_RESULT: exp_rd = exp_res;
			default:        exp_rd = {30'd0, exp_ill, exp_done};
		endcase
	end

	// RV32I subset, immediate compares use the immediate
	function automatic logic [`RV_XLEN-1:0] expected_result(
			input logic [`RV_XLEN-1:0] ins, a, b, addr);
		logic [`RV_XLEN-1:0] opb;
		logic                is_reg;
		is_reg = ins[6:0] == rv_isa_pkg::OP_REG;
		opb    = is_reg ? b : {{20{ins[31]}}, ins[31:20]};
		case (ins[6:0])
			rv_isa_pkg::OP_LUI:   return {ins[31:12], 12'h0};
			rv_isa_pkg::OP_AUIPC: return {ins[31:12], 12'h0} + addr;
			rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG: begin
				case (ins[14:12])
					rv_isa_pkg::F3_ADD:  return (is_reg && ins[30]) ? a - b : a + opb;
					rv_isa_pkg::F3_SLL:  return a << opb[4:0];
					rv_isa_pkg::F3_SLT:  return {31'd0, $signed(a) < $signed(opb)};
					rv_isa_pkg::F3_SLTU: return {31'd0, a < opb};
					rv_isa_pkg::F3_XOR:  return a ^ opb;
					rv_isa_pkg::F3_OR:   return a | opb;
					rv_isa_pkg::F3_AND:  return a & opb;
					default: begin // Right shifts
						if (ins[30])
							return $signed(a) >>> opb[4:0];
						return a >> opb[4:0];
					end
				endcase
			end
			default: return '0;
		endcase
	endfunction

	// Snoop completed writes, model runs when CTRL is written
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			instr    <= '0;
			rs1      <= '0;
			rs2      <= '0;
			pc       <= '0;
			exp_res  <= '0;
			exp_ill  <= 1'b0;
			exp_done <= 1'b0;
		end else if (access && pready_i && pwrite_i && !exp_err) begin
			case (paddr_i)
				`RV_REG_INSTR: instr <= pwdata_i;
				`RV_REG_RS1:   rs1   <= pwdata_i;
				`RV_REG_RS2:   rs2   <= pwdata_i;
				`RV_REG_PC:    pc    <= pwdata_i;
				default: begin
					exp_res  <= expected_result(instr, rs1, rs2, pc);
					exp_ill  <= !(instr[6:0] inside {rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC,
						rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG});
					exp_done <= 1'b1;
				end
			endcase
		end
	end

	// Two cycle launch latency, decode then result
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pend_dec  <= 1'b0;
			pend_exec <= 1'b0;
		end else begin
			pend_dec  <= launch_wr;
			pend_exec <= pend_dec;
		end
	end

	a_read: assert property (
		@(posedge clk_i) disable iff (reset_i)
		access && pready_i && !pwrite_i && rd_chk |-> prdata_i == exp_rd
	) else begin
		$error("ERROR %0t prdata at %02h expected %08h got %08h", $time,
			$sampled(paddr_i), $sampled(exp_rd), $sampled(prdata_i));
		fail_cnt++;
	end

	a_err: assert property (
		@(posedge clk_i) disable iff (reset_i)
		access && pready_i |-> pslverr_i == exp_err
	) else begin
		$error("ERROR %0t pslverr expected %0b got %0b", $time,
			$sampled(exp_err), $sampled(pslverr_i));
		fail_cnt++;
	end

	// Launch still in flight, so the read must wait
	a_stall: assert property (
		@(posedge clk_i) disable iff (reset_i)
		access && !pwrite_i && ro && in_flight |-> !pready_i
	) else begin
		$error("Result or status read completed while a launch was still in flight");
		fail_cnt++;
	end

	a_ready: assert property (
		@(posedge clk_i) disable iff (reset_i)
		access && !(ro && !pwrite_i && in_flight) |-> pready_i
	) else begin
		$error("Access was held off by pready with no launch in flight");
		fail_cnt++;
	end

	a_state: assert property (
		@(posedge clk_i) disable iff (reset_i)
		state_i == exp_state
	) else begin
		$error("ERROR %0t state expected %0d got %0d", $time,
			$sampled(exp_state), $sampled(state_i));
		fail_cnt++;
	end

	a_setup: assert property (
		@(posedge clk_i) disable iff (reset_i)
		!access |-> !pready_i
	) else begin
		$error("pready went high outside an access phase");
		fail_cnt++;
	end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o   = 1'b0;
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0; // Released on a falling edge
	end

	always #50 clk_o = ~clk_o; // 100 ns period

endmodule

// ==== rv_alu_top.sv ====
`timescale 1ns/1ps
`include "rv_alu_macros.svh"

module rv_alu_top (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic [`RV_APB_AW-1:0] paddr_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [`RV_XLEN-1:0]   pwdata_i,
	output logic [`RV_XLEN-1:0]   prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o
);

	logic [`RV_XLEN-1:0] instr, rs1, rs2, pc;
	logic                launch;
	rv_isa_pkg::opcode_e opcode;
	rv_isa_pkg::func3_e  func3;
	logic                func7_b5;
	logic [`RV_XLEN-1:0] imm, in0, in1, addr;
	logic                dec_valid, dec_illegal;
	logic [`RV_XLEN-1:0] alu_out, result;
	logic                done, illegal_flag, busy;

	rv_apb_regs u_regs (
		.clk_i, .reset_i,
		.paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
		.prdata_o, .pready_o, .pslverr_o,
		.result_i(result), .done_i(done), .illegal_i(illegal_flag), .busy_i(busy),
		.instr_o(instr), .rs1_o(rs1), .rs2_o(rs2), .pc_o(pc), .launch_o(launch)
	);

	rv_decode u_decode (
		.clk_i, .reset_i,
		.instr_i(instr), .rs1_i(rs1), .rs2_i(rs2), .pc_i(pc), .launch_i(launch),
		.opcode_o(opcode), .func3_o(func3), .func7_b5_o(func7_b5), .imm_o(imm),
		.in0_o(in0), .in1_o(in1), .addr_o(addr),
		.dec_valid_o(dec_valid), .illegal_o(dec_illegal)
	);

	rv_alu u_alu (
		.opcode_i(opcode), .func3_i(func3), .func7_b5_i(func7_b5), .imm_i(imm),
		.in0_i(in0), .in1_i(in1), .addr_i(addr), .out_o(alu_out)
	);

	rv_result u_result (
		.clk_i, .reset_i,
		.launch_i(launch), .dec_valid_i(dec_valid), .illegal_i(dec_illegal),
		.alu_out_i(alu_out),
		.result_o(result), .done_o(done), .illegal_o(illegal_flag), .busy_o(busy)
	);

endmodule

// ==== rv_result.sv ====
`timescale 1ns/1ps
`include "rv_alu_macros.svh"

module rv_result (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                launch_i,
	input  logic                dec_valid_i,
	input  logic                illegal_i,
	input  logic [`RV_XLEN-1:0] alu_out_i,
	output logic [`RV_XLEN-1:0] result_o,
	output logic                done_o,
	output logic                illegal_o,
	output logic                busy_o
);

	rv_bus_pkg::launch_state_e state;

	// Oldest launch wins when two are in flight
	always_comb begin
		if (dec_valid_i)
			state = rv_bus_pkg::LS_EXEC;
		else if (launch_i)
			state = rv_bus_pkg::LS_DECODE;
		else
			state = rv_bus_pkg::LS_IDLE;
	end

	assign busy_o = state != rv_bus_pkg::LS_IDLE;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			result_o  <= '0;
			done_o    <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			if (dec_valid_i) begin
				result_o  <= illegal_i ? '0 : alu_out_i;
				illegal_o <= illegal_i;
			end
			done_o <= ~launch_i & (dec_valid_i | done_o); // New launch clears
		end
	end

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_alu_macros.svh"

module rv_alu (
	input  rv_isa_pkg::opcode_e opcode_i,
	input  rv_isa_pkg::func3_e  func3_i,
	input  logic                func7_b5_i,
	input  logic [`RV_XLEN-1:0] imm_i,
	input  logic [`RV_XLEN-1:0] in0_i,
	input  logic [`RV_XLEN-1:0] in1_i,
	input  logic [`RV_XLEN-1:0] addr_i,
	output logic [`RV_XLEN-1:0] out_o
);

	localparam int SHW = $clog2(`RV_XLEN);

	logic [SHW-1:0] shamt_imm;
	logic [SHW-1:0] shamt_reg;
	logic           lt_imm_s;
	logic           lt_imm_u;
	logic           lt_reg_s;
	logic           lt_reg_u;

	assign shamt_imm = imm_i[SHW-1:0];
	assign shamt_reg = in1_i[SHW-1:0];

	// Compares against the immediate for SLTI and SLTIU
	assign lt_imm_s = $signed(in0_i) < $signed(imm_i);
	assign lt_imm_u = in0_i < imm_i;
	assign lt_reg_s = $signed(in0_i) < $signed(in1_i);
	assign lt_reg_u = in0_i < in1_i;

	always_comb begin
		out_o = '0;
		case (opcode_i)
			rv_isa_pkg::OP_LUI:   out_o = imm_i;
			rv_isa_pkg::OP_AUIPC: out_o = imm_i + addr_i;
			rv_isa_pkg::OP_IMM: begin
				case (func3_i)
					rv_isa_pkg::F3_ADD:  out_o = in0_i + imm_i;
					rv_isa_pkg::F3_SLT:  out_o = {{(`RV_XLEN-1){1'b0}}, lt_imm_s};
					rv_isa_pkg::F3_SLTU: out_o = {{(`RV_XLEN-1){1'b0}}, lt_imm_u};
					rv_isa_pkg::F3_XOR:  out_o = in0_i ^ imm_i;
					rv_isa_pkg::F3_OR:   out_o = in0_i | imm_i;
					rv_isa_pkg::F3_AND:  out_o = in0_i & imm_i;
					rv_isa_pkg::F3_SLL:  out_o = in0_i << shamt_imm;
					rv_isa_pkg::F3_SR: begin
						if (func7_b5_i)
							out_o = $signed(in0_i) >>> shamt_imm; // SRAI
						else
							out_o = in0_i >> shamt_imm;
					end
					default: ;
				endcase
			end
			rv_isa_pkg::OP_REG: begin
				case (func3_i)
					rv_isa_pkg::F3_ADD:  out_o = func7_b5_i ? in0_i - in1_i : in0_i + in1_i;
					rv_isa_pkg::F3_SLL:  out_o = in0_i << shamt_reg;
					rv_isa_pkg::F3_SLT:  out_o = {{(`RV_XLEN-1){1'b0}}, lt_reg_s};
					rv_isa_pkg::F3_SLTU: out_o = {{(`RV_XLEN-1){1'b0}}, lt_reg_u};
					rv_isa_pkg::F3_XOR:  out_o = in0_i ^ in1_i;
					rv_isa_pkg::F3_OR:   out_o = in0_i | in1_i;
					rv_isa_pkg::F3_AND:  out_o = in0_i & in1_i;
					rv_isa_pkg::F3_SR: begin
						if (func7_b5_i)
							out_o = $signed(in0_i) >>> shamt_reg; // SRA
						else
							out_o = in0_i >> shamt_reg;
					end
					default: ;
				endcase
			end
			default: ; // Anything else reads as zero
		endcase
	end

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_alu_macros.svh"

module rv_decode (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic [`RV_XLEN-1:0] instr_i,
	input  logic [`RV_XLEN-1:0] rs1_i,
	input  logic [`RV_XLEN-1:0] rs2_i,
	input  logic [`RV_XLEN-1:0] pc_i,
	input  logic                launch_i,
	output rv_isa_pkg::opcode_e opcode_o,
	output rv_isa_pkg::func3_e  func3_o,
	output logic                func7_b5_o,
	output logic [`RV_XLEN-1:0] imm_o,
	output logic [`RV_XLEN-1:0] in0_o,
	output logic [`RV_XLEN-1:0] in1_o,
	output logic [`RV_XLEN-1:0] addr_o,
	output logic                dec_valid_o,
	output logic                illegal_o
);

	rv_isa_pkg::opcode_e opcode;
	logic [`RV_XLEN-1:0] imm;
	logic                legal;

	assign opcode = rv_isa_pkg::opcode_e'(instr_i[6:0]);

	// Immediate by instruction format
	always_comb begin
		legal = 1'b1;
		case (opcode)
			rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC:
				imm = {instr_i[31:12], 12'b0};                       // U-type
			rv_isa_pkg::OP_IMM:
				imm = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]}; // I-type
			rv_isa_pkg::OP_REG:
				imm = '0;
			default: begin
				imm   = '0;
				legal = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			dec_valid_o <= 1'b0;
			illegal_o   <= 1'b0;
		end else begin
			dec_valid_o <= launch_i;
			if (launch_i)
				illegal_o <= ~legal;
		end
	end

	always_ff @(posedge clk_i) begin
		if (launch_i) begin
			opcode_o   <= opcode;
			func3_o    <= rv_isa_pkg::func3_e'(instr_i[14:12]);
			func7_b5_o <= instr_i[30];
			imm_o      <= imm;
			in0_o      <= rs1_i;
			in1_o      <= rs2_i;
			addr_o     <= pc_i;
		end
	end

endmodule

// ==== rv_apb_regs.sv ====
`timescale 1ns/1ps
`include "rv_alu_macros.svh"

module rv_apb_regs (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic [`RV_APB_AW-1:0] paddr_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [`RV_XLEN-1:0]   pwdata_i,
	output logic [`RV_XLEN-1:0]   prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	input  logic [`RV_XLEN-1:0]   result_i,
	input  logic                  done_i,
	input  logic                  illegal_i,
	input  logic                  busy_i,
	output logic [`RV_XLEN-1:0]   instr_o,
	output logic [`RV_XLEN-1:0]   rs1_o,
	output logic [`RV_XLEN-1:0]   rs2_o,
	output logic [`RV_XLEN-1:0]   pc_o,
	output logic                  launch_o
);

	logic                access;
	logic                ro_hit;
	logic                mapped;
	logic                wr_en;
	logic [`RV_XLEN-1:0] status;

	assign access = psel_i & penable_i;
	assign ro_hit = (paddr_i == `RV_REG_RESULT) | (paddr_i == `RV_REG_STATUS);

	always_comb begin
		case (paddr_i)
			`RV_REG_INSTR, `RV_REG_RS1, `RV_REG_RS2, `RV_REG_PC,
			`RV_REG_CTRL, `RV_REG_RESULT, `RV_REG_STATUS: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// Result and status reads wait for the pipeline to drain
	assign pready_o  = access & ~(ro_hit & ~pwrite_i & busy_i);
	assign pslverr_o = pready_o & (~mapped | (ro_hit & pwrite_i));
	assign wr_en     = pready_o & pwrite_i & ~pslverr_o;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			instr_o  <= '0;
			rs1_o    <= '0;
			rs2_o    <= '0;
			pc_o     <= '0;
			launch_o <= 1'b0;
		end else begin
			launch_o <= wr_en & (paddr_i == `RV_REG_CTRL); // Data ignored
			if (wr_en) begin
				case (paddr_i)
					`RV_REG_INSTR: instr_o <= pwdata_i;
					`RV_REG_RS1:   rs1_o   <= pwdata_i;
					`RV_REG_RS2:   rs2_o   <= pwdata_i;
					`RV_REG_PC:    pc_o    <= pwdata_i;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		status = '0;
		status[rv_bus_pkg::ST_DONE]    = done_i;
		status[rv_bus_pkg::ST_ILLEGAL] = illegal_i;
	end

	always_comb begin
		case (paddr_i)
			`RV_REG_INSTR:  prdata_o = instr_o;
			`RV_REG_RS1:    prdata_o = rs1_o;
			`RV_REG_RS2:    prdata_o = rs2_o;
			`RV_REG_PC:     prdata_o = pc_o;
			`RV_REG_RESULT: prdata_o = result_i;
			`RV_REG_STATUS: prdata_o = status;
			default:        prdata_o = '0; // CTRL and holes read zero
		endcase
	end

endmodule

// ==== rv_bus_pkg.sv ====
package rv_bus_pkg;

	// Where the oldest launch sits in the current cycle
	typedef enum logic [1:0] {
		LS_IDLE   = 2'd0,
		LS_DECODE = 2'd1, // Launch pulse up, decode registers next edge
		LS_EXEC   = 2'd2  // Decode valid, result captures next edge
	} launch_state_e;

	// Bit positions in STATUS
	typedef enum int unsigned {
		ST_DONE    = 0,
		ST_ILLEGAL = 1
	} status_bit_e;

endpackage

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

	// Major opcodes handled by the unit
	typedef enum logic [6:0] {
		OP_LUI   = 7'b0110111,
		OP_AUIPC = 7'b0010111,
		OP_IMM   = 7'b0010011, // ADDI and friends
		OP_REG   = 7'b0110011  // Register-register
	} opcode_e;

	// func3 encodings, shared by OP and OP-IMM
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000, // Also SUB
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101, // SRL or SRA by func7 bit 5
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} func3_e;

endpackage

// ==== rv_alu_macros.svh ====
`ifndef RV_ALU_MACROS_SVH
`define RV_ALU_MACROS_SVH

// Datapath width
`define RV_XLEN 32

// APB address width
`define RV_APB_AW 8

// Register map, byte offsets
`define RV_REG_INSTR  8'h00
`define RV_REG_RS1    8'h04
`define RV_REG_RS2    8'h08
`define RV_REG_PC     8'h0C
`define RV_REG_CTRL   8'h10 // Write only, any data launches
`define RV_REG_RESULT 8'h14 // Read only
`define RV_REG_STATUS 8'h18 // Read only

`endif
